// File: rtl/hockey_pkg.sv
`default_nettype none

package hockey_pkg;

    typedef logic [2:0] coord_t;    // puck column or lane
    typedef logic [1:0] score_t;
    typedef logic [6:0] seg_t;      // active low
    typedef logic [4:0] led_bar_t;

    localparam coord_t COL_A_END = 3'd0;
    localparam coord_t COL_B_END = 3'd4;
    localparam coord_t LANE_MAX = 3'd4;
    localparam score_t WIN_SCORE = 2'd3;
    localparam int DEFAULT_TICKS = 100;

    // digits 0 to 4 only
    localparam seg_t SEG_DIGIT [5] = '{
        7'b0000001,
        7'b1001111,
        7'b0010010,
        7'b0000110,
        7'b1001100
    };
    localparam seg_t SEG_LINE = 7'b1111110;
    localparam seg_t SEG_A = 7'b0001000;
    localparam seg_t SEG_B = 7'b1100000;
    localparam seg_t SEG_BLANK = 7'b1111111;
    localparam seg_t SEG_ERROR = 7'b0000000;   // every segment lit

    localparam led_bar_t LED_ALL = 5'b11111;
    localparam led_bar_t LED_COL0 = 5'b10000;  // column 0 sits on the top bit
    localparam led_bar_t LED_BLINK_EVEN = 5'b10101;
    localparam led_bar_t LED_BLINK_ODD = 5'b01010;

    // code 3 from the switch behaves as straight
    typedef enum logic [1:0] {
        straight = 2'd0,
        up = 2'd1,
        down = 2'd2
    } dir_t;

    typedef enum logic [3:0] {
        idle,
        start_show,
        serve_a,
        serve_b,
        to_b,
        to_a,
        respond_b,
        respond_a,
        goal_a,       // A has just scored
        goal_b,
        win
    } game_state_t;

    typedef struct packed {
        logic fire;
        dir_t dir;
        coord_t lane;
    } player_in_t;

    typedef struct packed {
        coord_t col;
        coord_t lane;
        dir_t dir;
    } puck_t;

    typedef struct packed {
        logic load;
        logic step;
        logic to_b;    // heading
        coord_t lane;
        dir_t dir;
    } puck_cmd_t;

    typedef struct packed {
        game_state_t state;
        score_t score_a;
        score_t score_b;
        puck_t puck;
        logic blink;
    } game_view_t;

    typedef seg_t [7:0] ssd_bank_t;

endpackage

`default_nettype wire

// File: rtl/puck_motion.sv
`timescale 1ns/1ps
`default_nettype none

module puck_motion (
    input wire clk,
    input wire rst,
    input wire hockey_pkg::puck_cmd_t cmd,
    output hockey_pkg::puck_t puck
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            puck.col <= hockey_pkg::COL_A_END;
            puck.lane <= '0;
            puck.dir <= hockey_pkg::straight;
        end else if (cmd.load) begin
            // start from the end the puck leaves
            puck.col <= cmd.to_b ? hockey_pkg::COL_A_END : hockey_pkg::COL_B_END;
            puck.lane <= cmd.lane;
            puck.dir <= cmd.dir;
        end else if (cmd.step) begin
            puck.col <= cmd.to_b ? puck.col + 3'd1 : puck.col - 3'd1;
            case (puck.dir)
                hockey_pkg::up: begin
                    if (puck.lane >= hockey_pkg::LANE_MAX) begin
                        puck.lane <= hockey_pkg::LANE_MAX - 3'd1;   // bounce off top
                        puck.dir <= hockey_pkg::down;
                    end else begin
                        puck.lane <= puck.lane + 3'd1;
                    end
                end
                hockey_pkg::down: begin
                    if (puck.lane == '0) begin
                        puck.lane <= 3'd1;
                        puck.dir <= hockey_pkg::up;
                    end else begin
                        puck.lane <= puck.lane - 3'd1;
                    end
                end
                default: begin
                    puck.lane <= puck.lane;   // straight holds its lane
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/game_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module game_ctrl #(
    parameter int tick_count = hockey_pkg::DEFAULT_TICKS
) (
    input wire clk,
    input wire rst,
    input wire hockey_pkg::player_in_t player_a,
    input wire hockey_pkg::player_in_t player_b,
    input wire hockey_pkg::puck_t puck,
    output hockey_pkg::puck_cmd_t cmd,
    output hockey_pkg::game_view_t view
);

    typedef logic [$clog2(tick_count + 1) - 1:0] tick_cnt_t;

    hockey_pkg::game_state_t state;
    hockey_pkg::game_state_t state_nxt;
    tick_cnt_t timer;
    logic tick_done;
    logic half_done;
    logic timer_wrap;
    logic server_b;      // first server, caught in idle
    logic hit;
    logic hit_now;
    logic hit_any;
    logic goal_for_a;
    logic goal_for_b;
    hockey_pkg::score_t score_a;
    hockey_pkg::score_t score_b;
    logic blink;

    assign tick_done = timer == tick_cnt_t'(tick_count - 1);
    assign half_done = timer == tick_cnt_t'(tick_count / 2 - 1);
    assign timer_wrap = (state == hockey_pkg::win) ? half_done : tick_done;

    // receiver on the puck lane with fire held
    assign hit_now = (state == hockey_pkg::respond_b) ?
                     (player_b.fire && player_b.lane == puck.lane) :
                     ((state == hockey_pkg::respond_a) && player_a.fire &&
                      player_a.lane == puck.lane);
    assign hit_any = hit | hit_now;

    always_comb begin
        state_nxt = state;
        cmd = '0;
        goal_for_a = 1'b0;
        goal_for_b = 1'b0;
        case (state)
            hockey_pkg::idle: begin
                if (player_a.fire != player_b.fire) begin
                    state_nxt = hockey_pkg::start_show;
                end
            end
            hockey_pkg::start_show: begin
                if (tick_done) begin
                    state_nxt = server_b ? hockey_pkg::serve_b : hockey_pkg::serve_a;
                end
            end
            hockey_pkg::serve_a: begin
                if (player_a.fire && player_a.lane <= hockey_pkg::LANE_MAX) begin
                    cmd.load = 1'b1;
                    cmd.to_b = 1'b1;
                    cmd.lane = player_a.lane;
                    cmd.dir = player_a.dir;
                    state_nxt = hockey_pkg::to_b;
                end
            end
            hockey_pkg::serve_b: begin
                if (player_b.fire && player_b.lane <= hockey_pkg::LANE_MAX) begin
                    cmd.load = 1'b1;
                    cmd.lane = player_b.lane;
                    cmd.dir = player_b.dir;
                    state_nxt = hockey_pkg::to_a;
                end
            end
            hockey_pkg::to_b: begin
                cmd.to_b = 1'b1;
                if (puck.col == hockey_pkg::COL_B_END) begin
                    state_nxt = hockey_pkg::respond_b;
                end else begin
                    cmd.step = tick_done;
                end
            end
            hockey_pkg::to_a: begin
                if (puck.col == hockey_pkg::COL_A_END) begin
                    state_nxt = hockey_pkg::respond_a;
                end else begin
                    cmd.step = tick_done;
                end
            end
            hockey_pkg::respond_b: begin
                if (tick_done && hit_any) begin
                    cmd.load = 1'b1;    // send it back the way it came
                    cmd.lane = puck.lane;
                    cmd.dir = puck.dir;
                    state_nxt = hockey_pkg::to_a;
                end else if (tick_done) begin
                    goal_for_a = 1'b1;
                    state_nxt = hockey_pkg::goal_a;
                end
            end
            hockey_pkg::respond_a: begin
                if (tick_done && hit_any) begin
                    cmd.load = 1'b1;
                    cmd.to_b = 1'b1;
                    cmd.lane = puck.lane;
                    cmd.dir = puck.dir;
                    state_nxt = hockey_pkg::to_b;
                end else if (tick_done) begin
                    goal_for_b = 1'b1;
                    state_nxt = hockey_pkg::goal_b;
                end
            end
            hockey_pkg::goal_a: begin
                if (tick_done) begin
                    state_nxt = (score_a == hockey_pkg::WIN_SCORE) ? hockey_pkg::win :
                                                                     hockey_pkg::serve_b;
                end
            end
            hockey_pkg::goal_b: begin
                if (tick_done) begin
                    state_nxt = (score_b == hockey_pkg::WIN_SCORE) ? hockey_pkg::win :
                                                                     hockey_pkg::serve_a;
                end
            end
            hockey_pkg::win: begin
                state_nxt = hockey_pkg::win;   // only reset leaves
            end
            default: begin
                state_nxt = hockey_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= hockey_pkg::idle;
            timer <= '0;
            server_b <= 1'b0;
            hit <= 1'b0;
            score_a <= '0;
            score_b <= '0;
            blink <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state || timer_wrap) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end
            if (state == hockey_pkg::idle) begin
                server_b <= player_b.fire;
            end
            hit <= (state == hockey_pkg::respond_a || state == hockey_pkg::respond_b) ?
                   hit_any : 1'b0;
            if (goal_for_a) begin
                score_a <= score_a + 1'b1;
            end
            if (goal_for_b) begin
                score_b <= score_b + 1'b1;
            end
            if (state == hockey_pkg::win && half_done) begin
                blink <= ~blink;
            end
        end
    end

    assign view = '{state: state, score_a: score_a, score_b: score_b, puck: puck,
                    blink: blink};

endmodule

`default_nettype wire

// File: rtl/panel_display.sv
`timescale 1ns/1ps
`default_nettype none

module panel_display (
    input wire hockey_pkg::game_view_t view,
    input wire hockey_pkg::coord_t lane_a,
    input wire hockey_pkg::coord_t lane_b,
    output logic led_a,
    output logic led_b,
    output hockey_pkg::led_bar_t led_x,
    output hockey_pkg::ssd_bank_t ssd
);

    hockey_pkg::seg_t seg_score_a;
    hockey_pkg::seg_t seg_score_b;
    hockey_pkg::seg_t seg_lane;

    function automatic hockey_pkg::seg_t digit_seg(input hockey_pkg::coord_t value);
        if (value >= $size(hockey_pkg::SEG_DIGIT)) begin
            digit_seg = hockey_pkg::SEG_ERROR;
        end else begin
            digit_seg = hockey_pkg::SEG_DIGIT[value];
        end
    endfunction

    assign seg_score_a = digit_seg(hockey_pkg::coord_t'(view.score_a));
    assign seg_score_b = digit_seg(hockey_pkg::coord_t'(view.score_b));
    assign seg_lane = digit_seg(view.puck.lane);

    always_comb begin
        led_a = 1'b0;
        led_b = 1'b0;
        led_x = '0;
        ssd = {8{hockey_pkg::SEG_BLANK}};
        case (view.state)
            hockey_pkg::idle: begin
                led_a = 1'b1;
                led_b = 1'b1;
                ssd[2] = hockey_pkg::SEG_A;
                ssd[1] = hockey_pkg::SEG_LINE;
                ssd[0] = hockey_pkg::SEG_B;
            end
            hockey_pkg::start_show: begin
                led_x = hockey_pkg::LED_ALL;
                ssd[2] = hockey_pkg::SEG_DIGIT[0];
                ssd[1] = hockey_pkg::SEG_LINE;
                ssd[0] = hockey_pkg::SEG_DIGIT[0];
            end
            hockey_pkg::serve_a: begin
                led_a = 1'b1;
                ssd[4] = digit_seg(lane_a);   // live switch, not the puck
            end
            hockey_pkg::serve_b: begin
                led_b = 1'b1;
                ssd[4] = digit_seg(lane_b);
            end
            hockey_pkg::to_a, hockey_pkg::to_b: begin
                led_x = hockey_pkg::LED_COL0 >> view.puck.col;
                ssd[4] = seg_lane;
            end
            hockey_pkg::respond_a: begin
                led_a = 1'b1;
                led_x = hockey_pkg::LED_COL0;
                ssd[4] = seg_lane;
            end
            hockey_pkg::respond_b: begin
                led_b = 1'b1;
                led_x = hockey_pkg::LED_COL0 >> hockey_pkg::COL_B_END;
                ssd[4] = seg_lane;
            end
            hockey_pkg::goal_a, hockey_pkg::goal_b: begin
                led_x = hockey_pkg::LED_ALL;
                ssd[2] = seg_score_a;
                ssd[1] = hockey_pkg::SEG_LINE;
                ssd[0] = seg_score_b;
            end
            hockey_pkg::win: begin
                led_x = view.blink ? hockey_pkg::LED_BLINK_ODD : hockey_pkg::LED_BLINK_EVEN;
                ssd[4] = (view.score_a == hockey_pkg::WIN_SCORE) ? hockey_pkg::SEG_A :
                                                                   hockey_pkg::SEG_B;
                ssd[2] = seg_score_a;
                ssd[1] = hockey_pkg::SEG_LINE;
                ssd[0] = seg_score_b;
            end
            default: begin
                led_x = '0;    // unused codes stay dark
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/hockey_top.sv
`timescale 1ns/1ps
`default_nettype none

module hockey_top #(
    parameter int tick_count = hockey_pkg::DEFAULT_TICKS
) (
    input wire clk,
    input wire rst,
    input wire hockey_pkg::player_in_t player_a,
    input wire hockey_pkg::player_in_t player_b,
    output logic led_a,
    output logic led_b,
    output hockey_pkg::led_bar_t led_x,
    output hockey_pkg::ssd_bank_t ssd
);

    hockey_pkg::puck_cmd_t cmd;
    hockey_pkg::puck_t puck;
    hockey_pkg::game_view_t view;

    game_ctrl #(
        .tick_count(tick_count)
    ) game_ctrl_i (
        .clk(clk),
        .rst(rst),
        .player_a(player_a),
        .player_b(player_b),
        .puck(puck),
        .cmd(cmd),
        .view(view)
    );

    puck_motion puck_motion_i (
        .clk(clk),
        .rst(rst),
        .cmd(cmd),
        .puck(puck)
    );

    // serve screens read the lane switches directly
    panel_display panel_display_i (
        .view(view),
        .lane_a(player_a.lane),
        .lane_b(player_b.lane),
        .led_a(led_a),
        .led_b(led_b),
        .led_x(led_x),
        .ssd(ssd)
    );

endmodule

`default_nettype wire

// File: verification/hockey_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hockey_assert (
    input wire clk,
    input wire rst,
    input wire hockey_pkg::game_view_t view,
    input wire hockey_pkg::led_bar_t led_x
);

    // one puck on the bar while it moves
    travel_one_hot: assert property (@(posedge clk) disable iff (rst)
        (view.state == hockey_pkg::to_a || view.state == hockey_pkg::to_b) |-> $onehot(led_x))
        else $error("led_x is not one-hot during travel");

    // play stops once a side holds the winning count
    score_limit: assert property (@(posedge clk) disable iff (rst)
        (view.score_a == hockey_pkg::WIN_SCORE || view.score_b == hockey_pkg::WIN_SCORE) |->
        (view.state == hockey_pkg::goal_a || view.state == hockey_pkg::goal_b ||
         view.state == hockey_pkg::win))
        else $error("winning count reached while play goes on");

    scores_only_rise: assert property (@(posedge clk) disable iff (rst)
        view.score_a >= $past(view.score_a) && view.score_b >= $past(view.score_b))
        else $error("a score went down");

    win_is_final: assert property (@(posedge clk) disable iff (rst)
        view.state == hockey_pkg::win |=> view.state == hockey_pkg::win)
        else $error("game left the win state");

endmodule

bind hockey_top hockey_assert hockey_assert_i (
    .clk(clk),
    .rst(rst),
    .view(view),
    .led_x(led_x)
);

`default_nettype wire

// File: verification/hockey_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hockey_tb;

    localparam int TICKS = 4;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic server_b;
        hockey_pkg::coord_t lane;
        logic [1:0] dir;      // raw switch code, 3 acts as straight
        logic returned;       // receiver hits once, then the server misses
        hockey_pkg::score_t score_a;
        hockey_pkg::score_t score_b;
    } rally_t;

    typedef enum {
        scr_idle, scr_start, scr_serve_a,
        scr_serve_b, scr_travel, scr_resp_a,
        scr_resp_b, scr_goal, scr_win
    } screen_t;

    // server, lane, dir, returned, expected score after the rally
    localparam rally_t RALLIES [5] = '{
        '{1'b0, 3'd2, 2'd1, 1'b0, 2'd1, 2'd0},
        '{1'b1, 3'd4, 2'd2, 1'b1, 2'd2, 2'd0},
        '{1'b1, 3'd0, 2'd3, 1'b0, 2'd2, 2'd1},
        '{1'b0, 3'd3, 2'd1, 1'b1, 2'd2, 2'd2},
        '{1'b0, 3'd1, 2'd2, 1'b0, 2'd3, 2'd2}
    };

    logic clk;
    logic rst;
    hockey_pkg::player_in_t player_a;
    hockey_pkg::player_in_t player_b;
    logic led_a;
    logic led_b;
    hockey_pkg::led_bar_t led_x;
    hockey_pkg::ssd_bank_t ssd;

    int error_count = 0;
    int errors_at_start = 0;
    int test_count = 0;
    int failed_tests = 0;
    int held;
    int seen_even;
    int seen_odd;
    int seen_other;

    hockey_top #(
        .tick_count(TICKS)
    ) hockey_top_i (
        .clk(clk),
        .rst(rst),
        .player_a(player_a),
        .player_b(player_b),
        .led_a(led_a),
        .led_b(led_b),
        .led_x(led_x),
        .ssd(ssd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
        assert (got === expected) else begin
            $display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("no progress: gave up waiting for %s at %0t ns", what, $time);
        error_count++;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count != errors_at_start) begin
            failed_tests++;
            $display("%s: FAIL", name);
        end else begin
            $display("%s: pass", name);
        end
        errors_at_start = error_count;
    endtask

    // lanes above 4 light every segment
    function automatic hockey_pkg::seg_t lane_pattern(input hockey_pkg::coord_t lane);
        if (lane > 3'd4) begin
            lane_pattern = 7'b0000000;
        end else begin
            lane_pattern = hockey_pkg::SEG_DIGIT[lane];
        end
    endfunction

    function automatic hockey_pkg::led_bar_t column_led(input bit toward_b, input int step);
        if (toward_b) begin
            column_led = 5'b10000 >> step;   // column 0 on bit 4
        end else begin
            column_led = 5'b00001 << step;
        end
    endfunction

    function automatic hockey_pkg::coord_t wrong_lane(input hockey_pkg::coord_t lane);
        wrong_lane = (lane == 3'd4) ? 3'd0 : lane + 3'd1;
    endfunction

    function automatic bit on_screen(input screen_t screen);
        case (screen)
            scr_idle: on_screen = led_a && led_b && led_x == 5'b00000;
            scr_start: on_screen = !led_a && !led_b && led_x == 5'b11111 &&
                                   ssd[2] == hockey_pkg::SEG_DIGIT[0] &&
                                   ssd[0] == hockey_pkg::SEG_DIGIT[0];
            scr_serve_a: on_screen = led_a && !led_b && led_x == 5'b00000;
            scr_serve_b: on_screen = led_b && !led_a && led_x == 5'b00000;
            scr_travel: on_screen = !led_a && !led_b && $onehot(led_x);
            scr_resp_a: on_screen = led_a && !led_b && led_x == 5'b10000;
            scr_resp_b: on_screen = led_b && !led_a && led_x == 5'b00001;
            scr_goal: on_screen = !led_a && !led_b && led_x == 5'b11111;
            scr_win: on_screen = !led_a && !led_b &&
                                 (led_x == 5'b10101 || led_x == 5'b01010);
            default: on_screen = 1'b0;
        endcase
    endfunction

    // bounce rule, lane moves with every column
    task automatic bounce_step(inout hockey_pkg::coord_t lane, inout logic [1:0] dir);
        if (dir == 2'd1) begin
            if (lane == 3'd4) begin
                lane = 3'd3;
                dir = 2'd2;
            end else begin
                lane = lane + 3'd1;
            end
        end else if (dir == 2'd2) begin
            if (lane == 3'd0) begin
                lane = 3'd1;
                dir = 2'd1;
            end else begin
                lane = lane - 3'd1;
            end
        end
    endtask

    task automatic predict_arrival(inout hockey_pkg::coord_t lane, inout logic [1:0] dir);
        repeat (4) bounce_step(lane, dir);
    endtask

    task automatic drive_player(input bit is_b, input logic fire,
                                input hockey_pkg::coord_t lane, input logic [1:0] dir);
        hockey_pkg::player_in_t p;
        p.fire = fire;
        p.dir = hockey_pkg::dir_t'(dir);
        p.lane = lane;
        @(posedge clk);
        if (is_b) begin
            player_b <= p;
        end else begin
            player_a <= p;
        end
    endtask

    task automatic wait_screen(input screen_t screen, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!on_screen(screen) && cycles < WAIT_LIMIT);
        if (!on_screen(screen)) begin
            report_timeout(what);
        end
    endtask

    task automatic measure_hold(input screen_t screen, output int count);
        count = 0;
        while (on_screen(screen) && count < WAIT_LIMIT) begin
            count++;
            @(negedge clk);
        end
    endtask

    task automatic serve_puck(input rally_t r);
        wait_screen(r.server_b ? scr_serve_b : scr_serve_a, "serve screen");
        for (int i = 0; i < 7; i++) begin
            drive_player(r.server_b, 1'b0, hockey_pkg::coord_t'(i), r.dir);
            @(negedge clk);
            check_eq(ssd[4], lane_pattern(hockey_pkg::coord_t'(i)), "serve lane digit");
        end
        // lane 6 is still set, so this press must be refused
        drive_player(r.server_b, 1'b1, 3'd6, r.dir);
        drive_player(r.server_b, 1'b0, 3'd6, r.dir);
        @(negedge clk);
        check_eq(on_screen(r.server_b ? scr_serve_b : scr_serve_a), 1'b1,
                 "serve screen after press with lane 6");
        drive_player(r.server_b, 1'b0, r.lane, r.dir);
        drive_player(r.server_b, 1'b1, r.lane, r.dir);
        drive_player(r.server_b, 1'b0, r.lane, r.dir);
    endtask

    task automatic follow_travel(input bit toward_b, input hockey_pkg::coord_t lane_in,
                                 input logic [1:0] dir_in);
        hockey_pkg::coord_t lane;
        logic [1:0] dir;
        int step;
        int cycles;
        lane = lane_in;
        dir = dir_in;
        step = 0;
        cycles = 0;
        wait_screen(scr_travel, "puck travel");
        while (!led_a && !led_b && cycles < WAIT_LIMIT) begin
            if (step < 4 && led_x == column_led(toward_b, step + 1)) begin
                step++;
                bounce_step(lane, dir);
            end
            check_eq(led_x, column_led(toward_b, step), "travel led_x");
            check_eq(ssd[4], lane_pattern(lane), "travel lane digit");
            @(negedge clk);
            cycles++;
        end
        if (!on_screen(toward_b ? scr_resp_b : scr_resp_a)) begin
            report_timeout("response window");
        end
        check_eq(step, 4, "columns crossed");
    endtask

    // short press on the given lane, then wait out the window
    task automatic answer(input bit is_b, input hockey_pkg::coord_t lane);
        int cycles;
        cycles = 0;
        drive_player(is_b, 1'b1, lane, 2'd0);
        drive_player(is_b, 1'b0, lane, 2'd0);   // the hit flag keeps the press
        do begin
            @(negedge clk);
            cycles++;
        end while (on_screen(is_b ? scr_resp_b : scr_resp_a) && cycles < WAIT_LIMIT);
        if (on_screen(is_b ? scr_resp_b : scr_resp_a)) begin
            report_timeout("end of response window");
        end
    endtask

    task automatic play_rally(input rally_t r);
        hockey_pkg::coord_t lane;
        logic [1:0] dir;
        int goal_held;
        lane = r.lane;
        dir = r.dir;
        serve_puck(r);
        follow_travel(!r.server_b, lane, dir);
        predict_arrival(lane, dir);
        check_eq(ssd[4], lane_pattern(lane), "lane at the receiver");
        if (r.returned) begin
            answer(!r.server_b, lane);
            follow_travel(r.server_b, lane, dir);
            predict_arrival(lane, dir);
            check_eq(ssd[4], lane_pattern(lane), "lane back at the server");
            answer(r.server_b, wrong_lane(lane));
        end else begin
            answer(!r.server_b, wrong_lane(lane));
        end
        // goal screen right after the missed window
        check_eq(on_screen(scr_goal), 1'b1, "goal screen after the window");
        check_eq(ssd[2], hockey_pkg::SEG_DIGIT[r.score_a], "goal digit 2");
        check_eq(ssd[1], hockey_pkg::SEG_LINE, "goal digit 1");
        check_eq(ssd[0], hockey_pkg::SEG_DIGIT[r.score_b], "goal digit 0");
        measure_hold(scr_goal, goal_held);
        check_eq(goal_held, TICKS, "goal screen cycles");
    endtask

    initial begin
        player_a = '0;
        player_b = '0;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_eq(on_screen(scr_idle), 1'b1, "idle leds");
        check_eq(ssd[2], hockey_pkg::SEG_A, "idle digit 2");
        check_eq(ssd[1], hockey_pkg::SEG_LINE, "idle digit 1");
        check_eq(ssd[0], hockey_pkg::SEG_B, "idle digit 0");
        check_eq(ssd[4], hockey_pkg::SEG_BLANK, "idle digit 4");
        check_eq(ssd[3], hockey_pkg::SEG_BLANK, "idle digit 3");
        check_eq(ssd[7:5], {3{hockey_pkg::SEG_BLANK}}, "idle digits 7 to 5");
        end_test("reset");

        drive_player(1'b0, 1'b1, 3'd0, 2'd0);    // A alone
        drive_player(1'b0, 1'b0, 3'd0, 2'd0);
        wait_screen(scr_start, "start screen");
        check_eq(ssd[1], hockey_pkg::SEG_LINE, "start digit 1");
        measure_hold(scr_start, held);
        check_eq(held, TICKS, "start screen cycles");
        end_test("start");

        for (int i = 0; i < 5; i++) begin
            play_rally(RALLIES[i]);
            end_test($sformatf("rally %0d", i));
        end

        wait_screen(scr_win, "win screen");
        check_eq(ssd[4], hockey_pkg::SEG_A, "winner letter");
        check_eq(ssd[2], hockey_pkg::SEG_DIGIT[3], "final score A");
        check_eq(ssd[0], hockey_pkg::SEG_DIGIT[2], "final score B");
        seen_even = 0;
        seen_odd = 0;
        seen_other = 0;
        repeat (4 * TICKS) begin
            @(negedge clk);
            if (led_x == 5'b10101) begin
                seen_even++;
            end else if (led_x == 5'b01010) begin
                seen_odd++;
            end else begin
                seen_other++;
            end
        end
        check_eq(seen_other, 0, "non-blink led_x in win");
        check_eq(seen_even > 0 && seen_odd > 0, 1'b1, "both blink halves seen");
        check_eq(ssd[4], hockey_pkg::SEG_A, "winner letter held");
        end_test("win");

        $display("%0d tests run, %0d failed, %0d check errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/hockey_pkg.sv
rtl/puck_motion.sv
rtl/game_ctrl.sv
rtl/panel_display.sv
rtl/hockey_top.sv
verification/hockey_assert.sv
verification/hockey_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = hockey_tb
FILE_LIST = list.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "no pass line"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
